// ==== design/soc_pkg.sv ====
/*
 * Shared bus types and SoC constants for the system-bus side.
 * Requests use a valid/ready handshake. A zero wstrb means a read.
 * Misc register indices come from address bits 6..2.
 */

`default_nettype none

package soc_pkg;

	// --------------------
	// Bus types
	// --------------------

	// Request from the bus master, held until ready
	typedef struct packed {
		logic        valid;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
	} bus_req_t;

	// Response back to the master
	typedef struct packed {
		logic        ready;
		logic [31:0] rdata;
	} bus_rsp_t;

	// --------------------
	// Address map
	// --------------------

	// Regions selected by address bits 31..28
	localparam logic [3:0] REGION_MISC = 4'h2;
	localparam logic [3:0] REGION_RAM  = 4'h4;

	// Misc register indices
	localparam logic [4:0] MISC_REG_LED       = 5'd0;
	localparam logic [4:0] MISC_REG_BTN       = 5'd1;
	localparam logic [4:0] MISC_REG_SOC_VER   = 5'd2;
	localparam logic [4:0] MISC_REG_FLASH_SEL = 5'd13;
	localparam logic [4:0] MISC_REG_GENIO_IN  = 5'd17;
	localparam logic [4:0] MISC_REG_GENIO_OUT = 5'd18;
	localparam logic [4:0] MISC_REG_GENIO_OE  = 5'd19;
	localparam logic [4:0] MISC_REG_GENIO_W2S = 5'd20;
	localparam logic [4:0] MISC_REG_GENIO_W2C = 5'd21;

	// --------------------
	// Constants
	// --------------------

	// Read data for accesses that hit no slave
	localparam logic [31:0] BUS_ERROR_WORD = 32'hDEAD_BEEF;

	localparam logic [31:0] SOC_VERSION = 32'h0000_0000;

	// Upper 24 bits of a flash select write that request an FPGA reload
	localparam logic [23:0] RELOAD_KEY = 24'hD0F1A5;

	// Start value of the flash select countdown
	localparam logic [2:0] FSEL_DELAY_START = 3'd7;

	// Interrupt vector bit positions
	// Bits 0..2 belong to the CPU and stay zero here
	localparam int IRQ_BUS_ERROR = 3;
	localparam int IRQ_USB       = 4;
	localparam int IRQ_COPPER    = 5;
	localparam int IRQ_AUDIO     = 6;

endpackage

`default_nettype wire

// ==== design/bus_decoder.sv ====
/*
 * Routes the single bus master to a slave by address bits 31..28.
 * Purely combinational. Slaves see valid only inside their own region.
 * Unmapped regions complete at once with the bus error word.
 */

`default_nettype none

module bus_decoder import soc_pkg::*; (
	input  bus_req_t bus_req_i,
	output bus_req_t misc_req_o,
	output bus_req_t ram_req_o,
	input  bus_rsp_t misc_rsp_i,
	input  bus_rsp_t ram_rsp_i,
	output bus_rsp_t bus_rsp_o,
	output logic     bus_error_o
);

	logic [3:0] region;
	logic       misc_hit;
	logic       ram_hit;

	assign region   = bus_req_i.addr[31:28];
	assign misc_hit = (region == REGION_MISC);
	assign ram_hit  = (region == REGION_RAM);

	// --------------------
	// Request gating
	// --------------------

	// Address and data go to every slave, valid only to the one selected
	always_comb begin
		misc_req_o = bus_req_i;
		misc_req_o.valid = bus_req_i.valid && misc_hit;
	end

	always_comb begin
		ram_req_o = bus_req_i;
		ram_req_o.valid = bus_req_i.valid && ram_hit;
	end

	// --------------------
	// Response mux
	// --------------------

	always_comb begin
		bus_rsp_o = '0;
		if (misc_hit) begin
			bus_rsp_o = misc_rsp_i;
		end else if (ram_hit) begin
			bus_rsp_o = ram_rsp_i;
		end else begin
			// Nothing lives here, answer in the same cycle
			bus_rsp_o.ready = bus_req_i.valid;
			bus_rsp_o.rdata = BUS_ERROR_WORD;
		end
	end

	// Raised for as long as an unmapped access is on the bus
	assign bus_error_o = bus_req_i.valid && !misc_hit && !ram_hit;

endmodule

`default_nettype wire

// ==== design/misc_regs.sv ====
/*
 * Misc register block. Answers every access with zero wait states.
 * Writes need wstrb bit 0. GENIO_W must not exceed 32.
 * The reload request is sticky until reset.
 */

`default_nettype none

module misc_regs import soc_pkg::*; #(
	parameter int GENIO_W = 30
) (
	input  logic               clk48m,
	input  logic               rst,
	input  bus_req_t           req_i,
	output bus_rsp_t           rsp_o,
	input  logic [7:0]         btn_i,
	output logic [15:0]        led_o,
	input  logic [GENIO_W-1:0] genio_in_i,
	output logic [GENIO_W-1:0] genio_out_o,
	output logic [GENIO_W-1:0] genio_oe_o,
	output logic               trace_en_o,
	output logic               fsel_d_o,
	output logic               fsel_strobe_o,
	output logic               reload_queue_o
);

	logic [4:0]         reg_idx;
	logic               wr_en;
	logic [GENIO_W-1:0] wr_genio;
	logic [31:0]        rd_data;

	assign reg_idx  = req_i.addr[6:2];
	assign wr_en    = req_i.valid && req_i.wstrb[0];
	assign wr_genio = req_i.wdata[GENIO_W-1:0];

	// --------------------
	// Read side
	// --------------------

	always_comb begin
		case (reg_idx)
			MISC_REG_LED:       rd_data = {16'h0, led_o};
			// Buttons are active low on the board
			MISC_REG_BTN:       rd_data = {24'h0, ~btn_i};
			MISC_REG_SOC_VER:   rd_data = SOC_VERSION;
			MISC_REG_FLASH_SEL: rd_data = {31'h0, fsel_d_o};
			MISC_REG_GENIO_IN:  rd_data = 32'(genio_in_i);
			MISC_REG_GENIO_OUT: rd_data = 32'(genio_out_o);
			MISC_REG_GENIO_OE:  rd_data = 32'(genio_oe_o);
			default:            rd_data = 32'h0;
		endcase
	end

	// No wait states, the access completes in the cycle it is seen
	assign rsp_o.ready = req_i.valid;
	assign rsp_o.rdata = rd_data;

	// --------------------
	// Write side
	// --------------------

	always_ff @(posedge clk48m) begin
		if (rst) begin
			led_o          <= '0;
			genio_out_o    <= '0;
			genio_oe_o     <= '0;
			trace_en_o     <= 1'b0;
			fsel_d_o       <= 1'b0;
			fsel_strobe_o  <= 1'b0;
			reload_queue_o <= 1'b0;
		end else begin
			fsel_strobe_o <= 1'b0;
			if (wr_en) begin
				case (reg_idx)
					MISC_REG_LED: begin
						led_o <= req_i.wdata[15:0];
					end
					MISC_REG_SOC_VER: begin
						// Version itself is read only, bit 0 drives trace enable
						trace_en_o <= req_i.wdata[0];
					end
					MISC_REG_FLASH_SEL: begin
						fsel_d_o      <= req_i.wdata[0];
						fsel_strobe_o <= 1'b1;
						if (req_i.wdata[31:8] == RELOAD_KEY) begin
							reload_queue_o <= 1'b1;
						end
					end
					MISC_REG_GENIO_OUT: begin
						genio_out_o <= wr_genio;
					end
					MISC_REG_GENIO_OE: begin
						genio_oe_o <= wr_genio;
					end
					// Set and clear aliases touch only the ones in wdata
					MISC_REG_GENIO_W2S: begin
						genio_out_o <= genio_out_o | wr_genio;
					end
					MISC_REG_GENIO_W2C: begin
						genio_out_o <= genio_out_o & ~wr_genio;
					end
					default: begin
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/fsel_sequencer.sv ====
/*
 * Flash select sequencer. A strobe restarts the countdown at 7.
 * The flash mux clock is high for three cycles of the count.
 * Once PROGRAMN drops it stays low until reset.
 */

`default_nettype none

module fsel_sequencer import soc_pkg::*; (
	input  logic clk48m,
	input  logic rst,
	input  logic fsel_strobe_i,
	input  logic reload_queue_i,
	output logic fsel_c_o,
	output logic programn_o
);

	// Count values that bound the mux clock pulse
	localparam logic [2:0] PULSE_FIRST = 3'd5;
	localparam logic [2:0] PULSE_LAST  = 3'd3;

	// Reload fires on the step from this value down to 1
	localparam logic [2:0] RELOAD_FROM = 3'd2;

	logic [2:0] count_q;
	logic       reload_q;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			count_q  <= 3'd0;
			reload_q <= 1'b0;
		end else if (fsel_strobe_i) begin
			count_q <= FSEL_DELAY_START;
		end else if (count_q != 3'd0) begin
			count_q <= count_q - 3'd1;
			// Mux data has long settled by now
			if (count_q == RELOAD_FROM && reload_queue_i) begin
				reload_q <= 1'b1;
			end
		end
	end

	assign fsel_c_o   = (count_q <= PULSE_FIRST) && (count_q >= PULSE_LAST);
	assign programn_o = ~reload_q;

endmodule

`default_nettype wire

// ==== design/word_ram.sv ====
/*
 * Word RAM with byte strobes in the main memory slot.
 * Ready comes one cycle after valid and lasts one cycle.
 * Address wraps modulo RAM_WORDS. Contents are undefined after power up.
 */

`default_nettype none

module word_ram import soc_pkg::*; #(
	parameter int RAM_WORDS = 256
) (
	input  logic     clk48m,
	input  logic     rst,
	input  bus_req_t req_i,
	output bus_rsp_t rsp_o
);

	localparam int AW = $clog2(RAM_WORDS);

	logic [31:0]   mem_q [RAM_WORDS];
	logic [31:0]   rdata_q;
	logic          ready_q;
	logic [AW-1:0] idx;

	assign idx = req_i.addr[AW+1:2];

	// Access happens at the first edge of a beat
	always_ff @(posedge clk48m) begin
		if (req_i.valid && !ready_q) begin
			for (int b = 0; b < 4; b++) begin
				if (req_i.wstrb[b]) begin
					mem_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
				end
			end
			rdata_q <= mem_q[idx];
		end
	end

	// Low again right after a completed beat so each beat sees one ready
	always_ff @(posedge clk48m) begin
		if (rst) begin
			ready_q <= 1'b0;
		end else begin
			ready_q <= req_i.valid && !ready_q;
		end
	end

	assign rsp_o.ready = ready_q;
	assign rsp_o.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== design/soc_top.sv ====
/*
 * System bus top level. One external master, misc registers and word RAM.
 * The interrupt vector is level based and carries no latching.
 */

`default_nettype none

module soc_top import soc_pkg::*; #(
	parameter int GENIO_W   = 30,
	parameter int RAM_WORDS = 256
) (
	input  logic               clk48m,
	input  logic               rst,
	input  bus_req_t           bus_req_i,
	output bus_rsp_t           bus_rsp_o,
	input  logic [7:0]         btn_i,
	output logic [15:0]        led_o,
	input  logic [GENIO_W-1:0] genio_in_i,
	output logic [GENIO_W-1:0] genio_out_o,
	output logic [GENIO_W-1:0] genio_oe_o,
	output logic               fsel_d_o,
	output logic               fsel_c_o,
	output logic               programn_o,
	output logic               trace_en_o,
	input  logic               usb_irq_i,
	input  logic               copper_irq_i,
	input  logic               audio_irq_i,
	output logic [31:0]        irq_o
);

	bus_req_t misc_req;
	bus_req_t ram_req;
	bus_rsp_t misc_rsp;
	bus_rsp_t ram_rsp;
	logic     bus_error;
	logic     fsel_strobe;
	logic     reload_queue;

	// --------------------
	// Bus fabric and slaves
	// --------------------

	bus_decoder u_decoder (
		.bus_req_i  (bus_req_i),
		.misc_req_o (misc_req),
		.ram_req_o  (ram_req),
		.misc_rsp_i (misc_rsp),
		.ram_rsp_i  (ram_rsp),
		.bus_rsp_o  (bus_rsp_o),
		.bus_error_o(bus_error)
	);

	misc_regs #(
		.GENIO_W(GENIO_W)
	) u_misc (
		.clk48m        (clk48m),
		.rst           (rst),
		.req_i         (misc_req),
		.rsp_o         (misc_rsp),
		.btn_i         (btn_i),
		.led_o         (led_o),
		.genio_in_i    (genio_in_i),
		.genio_out_o   (genio_out_o),
		.genio_oe_o    (genio_oe_o),
		.trace_en_o    (trace_en_o),
		.fsel_d_o      (fsel_d_o),
		.fsel_strobe_o (fsel_strobe),
		.reload_queue_o(reload_queue)
	);

	fsel_sequencer u_fsel (
		.clk48m        (clk48m),
		.rst           (rst),
		.fsel_strobe_i (fsel_strobe),
		.reload_queue_i(reload_queue),
		.fsel_c_o      (fsel_c_o),
		.programn_o    (programn_o)
	);

	word_ram #(
		.RAM_WORDS(RAM_WORDS)
	) u_ram (
		.clk48m(clk48m),
		.rst   (rst),
		.req_i (ram_req),
		.rsp_o (ram_rsp)
	);

	// --------------------
	// Interrupt vector
	// --------------------

	always_comb begin
		irq_o = 32'h0;
		irq_o[IRQ_BUS_ERROR] = bus_error;
		irq_o[IRQ_USB]       = usb_irq_i;
		irq_o[IRQ_COPPER]    = copper_irq_i;
		irq_o[IRQ_AUDIO]     = audio_irq_i;
	end

endmodule

`default_nettype wire

// ==== bench/tb_checks.svh ====
/*
 * Compare tasks and random source for the SoC testbench.
 * Included inside tb_soc and relies on fail_run and the soc_pkg types there.
 */

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// --------------------
// Compare tasks
// --------------------

// Read data of a completed beat
task automatic check_rsp(input bus_rsp_t got, input logic [31:0] exp_rdata);
	if (got.rdata !== exp_rdata) begin
		fail_run($sformatf("Mismatch bus_rsp_o.rdata got %08h expected %08h",
			got.rdata, exp_rdata));
	end
endtask

// Whole interrupt vector, so stray bits show up too
task automatic check_irq(input logic [31:0] got, input logic [31:0] exp_irq);
	if (got !== exp_irq) begin
		fail_run($sformatf("Mismatch irq_o got %08h expected %08h", got, exp_irq));
	end
endtask

// Any output pin, widened to 32 bits
task automatic check_pins(input string name, input logic [31:0] got,
		input logic [31:0] exp_val);
	if (got !== exp_val) begin
		fail_run($sformatf("Mismatch %s got %08h expected %08h", name, got, exp_val));
	end
endtask

// --------------------
// Random data
// --------------------

// Numerical Recipes LCG step
function automatic logic [31:0] lcg_next(input logic [31:0] state);
	return state * 32'd1664525 + 32'd1013904223;
endfunction

`endif

// ==== bench/tb_soc.sv ====
/*
 * Testbench for soc_top. Reads bench/soc_patterns.hex, so run it from the
 * project root. The random RAM test uses words 64..79 of the RAM.
 * The reload sequence runs last since PROGRAMN stays low until reset.
 */

`default_nettype none

module tb_soc import soc_pkg::*; ();

	localparam int GENIO_W    = 30;
	localparam int RAM_WORDS  = 256;
	localparam int MAX_PATS   = 64;
	localparam int RAND_WORDS = 16;

	logic               clk48m;
	logic               rst;
	bus_req_t           bus_req;
	bus_rsp_t           bus_rsp;
	logic [7:0]         btn;
	logic [15:0]        led;
	logic [GENIO_W-1:0] genio_in;
	logic [GENIO_W-1:0] genio_out;
	logic [GENIO_W-1:0] genio_oe;
	logic               fsel_d;
	logic               fsel_c;
	logic               programn;
	logic               trace_en;
	logic               usb_irq;
	logic               copper_irq;
	logic               audio_irq;
	logic [31:0]        irq;

	// Five words per operation of kind, addr, wdata, wstrb and expected
	logic [31:0] pat_mem [5*MAX_PATS];
	logic [31:0] shadow [RAND_WORDS];
	logic [31:0] lcg_state;
	int          n_pats;
	int          cycle_count = 0;
	int          cycle_limit = 1000;

	soc_top #(
		.GENIO_W  (GENIO_W),
		.RAM_WORDS(RAM_WORDS)
	) DUT (
		.clk48m      (clk48m),
		.rst         (rst),
		.bus_req_i   (bus_req),
		.bus_rsp_o   (bus_rsp),
		.btn_i       (btn),
		.led_o       (led),
		.genio_in_i  (genio_in),
		.genio_out_o (genio_out),
		.genio_oe_o  (genio_oe),
		.fsel_d_o    (fsel_d),
		.fsel_c_o    (fsel_c),
		.programn_o  (programn),
		.trace_en_o  (trace_en),
		.usb_irq_i   (usb_irq),
		.copper_irq_i(copper_irq),
		.audio_irq_i (audio_irq),
		.irq_o       (irq)
	);

	initial clk48m = 1'b0;
	always #10 clk48m = ~clk48m;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1, "stopped at first error");
	endtask

	`include "tb_checks.svh"

	always @(posedge clk48m) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			fail_run($sformatf("Timeout, run did not finish within %0d cycles", cycle_limit));
		end
	end

	// --------------------
	// Bus driver
	// --------------------

	// Drives one beat and returns at the negedge after the idle cycle
	task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
			input logic [3:0] wstrb, output bus_rsp_t rsp);
		bus_req_t    req;
		logic [31:0] exp_irq;
		logic        unmapped;
		int          waits;
		int          exp_waits;
		unmapped = (addr[31:28] != REGION_MISC) && (addr[31:28] != REGION_RAM);
		exp_waits = (addr[31:28] == REGION_RAM) ? 1 : 0;
		exp_irq = 32'h0;
		exp_irq[IRQ_BUS_ERROR] = unmapped;
		waits = 0;
		req.valid = 1'b1;
		req.addr = addr;
		req.wdata = wdata;
		req.wstrb = wstrb;
		@(posedge clk48m);
		bus_req <= req;
		@(negedge clk48m);
		while (!bus_rsp.ready) begin
			check_irq(irq, exp_irq);
			waits++;
			@(negedge clk48m);
		end
		check_irq(irq, exp_irq);
		if (waits != exp_waits) begin
			fail_run($sformatf("Beat at %08h got ready after %0d wait cycles instead of %0d",
				addr, waits, exp_waits));
		end
		rsp = bus_rsp;
		if (unmapped) begin
			check_rsp(rsp, BUS_ERROR_WORD);
		end
		@(posedge clk48m);
		bus_req <= '0;
		@(negedge clk48m);
		if (bus_rsp.ready) begin
			fail_run($sformatf("Ready still high in the cycle after the beat at %08h", addr));
		end
		check_irq(irq, 32'h0);
	endtask

	task automatic check_pin_code(input logic [31:0] code, input logic [31:0] exp_val);
		case (code)
			0: check_pins("led_o", 32'(led), exp_val);
			1: check_pins("genio_out_o", 32'(genio_out), exp_val);
			2: check_pins("genio_oe_o", 32'(genio_oe), exp_val);
			3: check_pins("trace_en_o", 32'(trace_en), exp_val);
			4: check_pins("fsel_d_o", 32'(fsel_d), exp_val);
			default: fail_run($sformatf("Unknown pin code %0h in pattern file", code));
		endcase
	endtask

	task automatic run_patterns();
		bus_rsp_t    rsp;
		logic [31:0] kind;
		for (int i = 0; i < n_pats; i++) begin
			kind = pat_mem[5*i];
			case (kind)
				0: bus_access(pat_mem[5*i+1], pat_mem[5*i+2], 4'(pat_mem[5*i+3]), rsp);
				1: begin
					bus_access(pat_mem[5*i+1], pat_mem[5*i+2], 4'(pat_mem[5*i+3]), rsp);
					check_rsp(rsp, pat_mem[5*i+4]);
				end
				2: check_pin_code(pat_mem[5*i+1], pat_mem[5*i+4]);
				default: fail_run($sformatf("Unknown operation kind %0h in pattern file", kind));
			endcase
		end
	endtask

	// Full words first, then one byte lane each, then read all back
	task automatic run_ram_random();
		bus_rsp_t    rsp;
		logic [31:0] data;
		logic [3:0]  strb;
		int          w;
		for (int i = 0; i < 2 * RAND_WORDS; i++) begin
			w = i % RAND_WORDS;
			lcg_state = lcg_next(lcg_state);
			data = lcg_state;
			strb = (i < RAND_WORDS) ? 4'hF : 4'(1 << (i % 4));
			bus_access(32'h4000_0100 + 32'(4 * w), data, strb, rsp);
			for (int b = 0; b < 4; b++) begin
				if (strb[b]) begin
					shadow[w][8*b +: 8] = data[8*b +: 8];
				end
			end
		end
		for (int i = 0; i < RAND_WORDS; i++) begin
			bus_access(32'h4000_0100 + 32'(4 * i), 32'h0, 4'h0, rsp);
			check_rsp(rsp, shadow[i]);
		end
	endtask

	// --------------------
	// Flash select and IRQ
	// --------------------

	// Sample k sits between edges Ek and Ek+1 of the sequence
	task automatic run_fsel_sequence(input logic [31:0] wdata);
		bus_rsp_t rsp;
		logic     key;
		logic     exp_c;
		logic     exp_n;
		key = (wdata[31:8] == RELOAD_KEY);
		bus_access({REGION_MISC, 21'h0, MISC_REG_FLASH_SEL, 2'b00}, wdata, 4'hF, rsp);
		check_pins("fsel_d_o", 32'(fsel_d), 32'(wdata[0]));
		for (int k = 1; k <= 10; k++) begin
			@(negedge clk48m);
			exp_c = (k >= 3) && (k <= 5);
			exp_n = !(key && (k >= 7));
			check_pins("fsel_c_o", 32'(fsel_c), 32'(exp_c));
			check_pins("programn_o", 32'(programn), 32'(exp_n));
		end
	endtask

	task automatic run_irq_inputs();
		logic [31:0] exp_irq;
		logic [2:0]  combo;
		for (int c = 0; c < 8; c++) begin
			combo = 3'(c);
			@(posedge clk48m);
			usb_irq <= combo[0];
			copper_irq <= combo[1];
			audio_irq <= combo[2];
			@(negedge clk48m);
			exp_irq = 32'h0;
			exp_irq[IRQ_USB] = combo[0];
			exp_irq[IRQ_COPPER] = combo[1];
			exp_irq[IRQ_AUDIO] = combo[2];
			check_irq(irq, exp_irq);
		end
		// Inputs back to idle so later beats see a clean vector
		@(posedge clk48m);
		usb_irq <= 1'b0;
		copper_irq <= 1'b0;
		audio_irq <= 1'b0;
		@(negedge clk48m);
		check_irq(irq, 32'h0);
	endtask

	initial begin
		rst = 1'b1;
		bus_req = '0;
		btn = 8'h5A;
		genio_in = 30'h1234_5678;
		usb_irq = 1'b0;
		copper_irq = 1'b0;
		audio_irq = 1'b0;
		lcg_state = 32'h90bf_12f8;
		$readmemh("bench/soc_patterns.hex", pat_mem);
		n_pats = 0;
		while (n_pats < MAX_PATS && pat_mem[5*n_pats] !== 32'hF) begin
			n_pats++;
		end
		if (n_pats == MAX_PATS) begin
			fail_run("Pattern file is missing or has no end marker");
		end
		cycle_limit = n_pats * 8 + 200;
		repeat (3) @(posedge clk48m);
		rst <= 1'b0;
		@(negedge clk48m);
		check_pins("bus_rsp_o.ready", 32'(bus_rsp.ready), 32'h0);
		check_irq(irq, 32'h0);
		check_pins("led_o", 32'(led), 32'h0);
		check_pins("genio_out_o", 32'(genio_out), 32'h0);
		check_pins("genio_oe_o", 32'(genio_oe), 32'h0);
		check_pins("trace_en_o", 32'(trace_en), 32'h0);
		check_pins("fsel_d_o", 32'(fsel_d), 32'h0);
		check_pins("fsel_c_o", 32'(fsel_c), 32'h0);
		check_pins("programn_o", 32'(programn), 32'h1);
		run_patterns();
		run_ram_random();
		run_fsel_sequence(32'h0000_0001);
		run_irq_inputs();
		run_fsel_sequence({RELOAD_KEY, 8'h00});
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/soc_patterns.hex ====
// kind addr wdata wstrb expected, kind 0 write, 1 read and compare,
// 2 pin check with the pin code in addr (0 led 1 gout 2 goe 3 trace 4 fsel_d), F end
0 20000000 0000A5C3 F 00000000
1 20000000 00000000 0 0000A5C3
2 00000000 00000000 0 0000A5C3
1 20000004 00000000 0 000000A5
1 20000008 00000000 0 00000000
0 20000008 00000001 1 00000000
2 00000003 00000000 0 00000001
1 20000008 00000000 0 00000000
1 20000044 00000000 0 12345678
0 20000048 0F0F00F0 F 00000000
1 20000048 00000000 0 0F0F00F0
0 20000050 10000003 F 00000000
2 00000001 00000000 0 1F0F00F3
0 20000054 000000F1 F 00000000
1 20000048 00000000 0 1F0F0002
0 2000004C 3FFF0001 F 00000000
2 00000002 00000000 0 3FFF0001
1 2000003C 00000000 0 00000000
0 40000000 11223344 F 00000000
0 40000000 000000AA 1 00000000
0 40000000 00BB0000 4 00000000
1 40000000 00000000 0 11BB33AA
1 00000010 00000000 0 DEADBEEF
0 F0000000 12345678 F 00000000
F 00000000 00000000 0 00000000

// ==== sim.f ====
+incdir+bench
design/soc_pkg.sv
design/bus_decoder.sv
design/misc_regs.sv
design/fsel_sequencer.sv
design/word_ram.sv
design/soc_top.sv
bench/tb_soc.sv

// ==== Bender.yml ====
package:
  name: soc_bus

sources:
  - design/soc_pkg.sv
  - design/bus_decoder.sv
  - design/misc_regs.sv
  - design/fsel_sequencer.sv
  - design/word_ram.sv
  - design/soc_top.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/tb_soc.sv
